// File: hdl/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// --------------------
// core widths
// --------------------
`define XLEN       32               // data and address width
`define REG_ADDR_W 5                // 32 architectural regs

// --------------------
// fetch constants
// --------------------
`define RESET_PC   32'h0000_0000    // first fetch address

// addi x0,x0,0, used for every bubble slot
`define NOP_INSTR  32'h0000_0013

`endif

// File: hdl/core_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

	typedef logic [`XLEN-1:0]       word_t;       // one data word
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;   // register index

	// rv32i major opcodes kept in this core
	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,   // add sub and or xor slt
		OP_IMM    = 7'b0010011,   // addi only
		OP_LOAD   = 7'b0000011,   // lw only
		OP_STORE  = 7'b0100011,   // sw only
		OP_BRANCH = 7'b1100011    // beq bne
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,                  // also address calc
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT                   // signed compare
	} alu_op_e;

	// --------------------
	// stage payloads
	// --------------------
	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;         // operand b from imm
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    is_branch;
		logic    branch_ne;       // bne, else beq
	} ctrl_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     rs1_data;
		word_t     rs2_data;
		word_t     imm;
		ctrl_t     ctrl;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     alu_result;    // result or mem address
		word_t     store_data;
		ctrl_t     ctrl;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		logic      reg_write;
		word_t     write_data;
	} mem_wb_t;

	// --------------------
	// wishbone classic
	// --------------------
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat_w;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat_r;             // sampled in ack cycle
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module fetch_unit import core_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  hold,          // mem stall or load-use
	input  logic  redirect,      // taken branch from execute
	input  word_t redirect_pc,
	input  word_t instr,         // rom data for pc, same cycle
	output word_t pc,
	output word_t fd_instr,
	output word_t fd_pc,
	output logic  fd_valid
);

word_t fd_instr_q;           // raw fetched word

// --------------------
// program counter
// --------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc <= `RESET_PC;
	end else if (redirect) begin
		pc <= redirect_pc;       // branch target next cycle
	end else if (!hold) begin
		pc <= pc + word_t'(4);   // predict not taken
	end
end

// --------------------
// fetch to decode reg
// --------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		fd_valid <= 1'b0;
	end else if (redirect) begin
		fd_valid <= 1'b0;        // kill wrong-path fetch
	end else if (!hold) begin
		fd_valid <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (!hold) begin
		fd_instr_q <= instr;
		fd_pc      <= pc;
	end
end

// dead slot decodes as a nop
assign fd_instr = fd_valid ? fd_instr_q : `NOP_INSTR;

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module decoder import core_pkg::*; (
	input  word_t     instr,
	input  word_t     pc,
	input  word_t     rs1_data,      // from regfile, write-first
	input  word_t     rs2_data,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output id_ex_t    decoded
);

opcode_e   opcode;
reg_addr_t rd;
logic [2:0] funct3;
logic      funct7_b5;               // sub vs add
word_t     imm_i;
word_t     imm_s;
word_t     imm_b;
word_t     imm;
ctrl_t     ctrl;

// --------------------
// fields
// --------------------
assign opcode    = opcode_e'(instr[6:0]);
assign rd        = instr[11:7];
assign funct3    = instr[14:12];
assign rs1       = instr[19:15];
assign rs2       = instr[24:20];
assign funct7_b5 = instr[30];

// sign-extended immediates
assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

// --------------------
// control decode
// --------------------
always_comb begin
	ctrl = '0;                      // unsupported -> bubble
	imm  = '0;
	case (opcode)
		OP_REG: begin
			ctrl.reg_write = 1'b1;
			case ({funct7_b5, funct3})
				4'b0_000: ctrl.alu_op = ALU_ADD;
				4'b1_000: ctrl.alu_op = ALU_SUB;
				4'b0_111: ctrl.alu_op = ALU_AND;
				4'b0_110: ctrl.alu_op = ALU_OR;
				4'b0_100: ctrl.alu_op = ALU_XOR;
				4'b0_010: ctrl.alu_op = ALU_SLT;
				default:  ctrl = '0;
			endcase
		end
		OP_IMM: if (funct3 == 3'b000) begin   // addi
			ctrl.reg_write = 1'b1;
			ctrl.use_imm   = 1'b1;
			imm            = imm_i;
		end
		OP_LOAD: if (funct3 == 3'b010) begin  // lw
			ctrl.reg_write = 1'b1;
			ctrl.mem_read  = 1'b1;
			ctrl.use_imm   = 1'b1;
			imm            = imm_i;
		end
		OP_STORE: if (funct3 == 3'b010) begin // sw
			ctrl.mem_write = 1'b1;
			ctrl.use_imm   = 1'b1;
			imm            = imm_s;
		end
		OP_BRANCH: if (funct3[2:1] == 2'b00) begin
			ctrl.is_branch = 1'b1;
			ctrl.branch_ne = funct3[0];   // 001 is bne
			imm            = imm_b;
		end
		default: ctrl = '0;
	endcase
end

always_comb begin
	decoded          = '0;
	decoded.valid    = 1'b0;        // set from fd_valid in data_path
	decoded.pc       = pc;
	decoded.rs1      = rs1;
	decoded.rs2      = rs2;
	decoded.rd       = rd;
	decoded.rs1_data = rs1_data;
	decoded.rs2_data = rs2_data;
	decoded.imm      = imm;
	decoded.ctrl     = ctrl;
end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module regfile (
	input  logic                   clk,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	output logic [`XLEN-1:0]       rs1_data,
	output logic [`XLEN-1:0]       rs2_data,
	input  logic                   we,
	input  logic [`REG_ADDR_W-1:0] rd,
	input  logic [`XLEN-1:0]       wdata
);

logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

always_ff @(posedge clk) begin
	if (we) regs[rd] <= wdata;      // x0 written but never read
end

// x0 is zero, then write-first, then storage
assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module execute_stage import core_pkg::*; (
	input  id_ex_t  id_ex,
	input  ex_mem_t ex_mem,          // newest forward source
	input  mem_wb_t mem_wb,          // older forward source
	output ex_mem_t result,
	output logic    redirect,
	output word_t   redirect_pc
);

word_t op_a;
word_t op_b_reg;                     // bypassed rs2, also store data
word_t op_b;
word_t alu_y;
logic  equal;

// --------------------
// bypass
// --------------------
function automatic word_t bypass(input reg_addr_t rs, input word_t reg_data,
		input ex_mem_t em, input mem_wb_t mw);
	word_t val;
	if (rs != '0 && em.valid && em.ctrl.reg_write && !em.ctrl.mem_read && em.rd == rs)
		val = em.alu_result;         // load in ex_mem is stalled away
	else if (rs != '0 && mw.valid && mw.reg_write && mw.rd == rs)
		val = mw.write_data;
	else
		val = reg_data;
	return val;
endfunction

always_comb begin
	op_a     = bypass(id_ex.rs1, id_ex.rs1_data, ex_mem, mem_wb);
	op_b_reg = bypass(id_ex.rs2, id_ex.rs2_data, ex_mem, mem_wb);
	op_b     = id_ex.ctrl.use_imm ? id_ex.imm : op_b_reg;
end

// --------------------
// alu
// --------------------
always_comb begin
	case (id_ex.ctrl.alu_op)
		ALU_ADD: alu_y = op_a + op_b;   // lw/sw address too
		ALU_SUB: alu_y = op_a - op_b;
		ALU_AND: alu_y = op_a & op_b;
		ALU_OR:  alu_y = op_a | op_b;
		ALU_XOR: alu_y = op_a ^ op_b;
		ALU_SLT: alu_y = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
		default: alu_y = op_a + op_b;
	endcase
end

// --------------------
// branch judge
// --------------------
assign equal       = (op_a == op_b_reg);
assign redirect    = id_ex.valid & id_ex.ctrl.is_branch & (equal ^ id_ex.ctrl.branch_ne);
assign redirect_pc = id_ex.pc + id_ex.imm;     // pc-relative target

always_comb begin
	result            = '0;
	result.valid      = id_ex.valid;
	result.rd         = id_ex.rd;
	result.alu_result = alu_y;
	result.store_data = op_b_reg;
	result.ctrl       = id_ex.ctrl;
end

endmodule

`default_nettype wire

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import core_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  ex_mem_t ex_mem,
	output wb_req_t dmem_req,
	input  wb_rsp_t dmem_rsp,
	output mem_wb_t result,
	output logic    mem_busy        // freezes whole pipe
);

logic access;                       // valid lw or sw here
logic ack_q;                        // acked last cycle, force idle
logic acked;

assign access = ex_mem.valid & (ex_mem.ctrl.mem_read | ex_mem.ctrl.mem_write);
assign acked  = dmem_req.stb & dmem_rsp.ack;

// --------------------
// wishbone master
// --------------------
always_comb begin
	dmem_req       = '0;
	dmem_req.cyc   = access & ~ack_q;       // held stable by the freeze
	dmem_req.stb   = access & ~ack_q;
	dmem_req.we    = ex_mem.ctrl.mem_write;
	dmem_req.adr   = ex_mem.alu_result;
	dmem_req.dat_w = ex_mem.store_data;
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		ack_q <= 1'b0;
	end else begin
		ack_q <= acked;              // drop cyc/stb one cycle
	end
end

// busy until the ack cycle, incl. the idle gap
assign mem_busy = access & ~acked;

// --------------------
// writeback payload
// --------------------
always_comb begin
	result            = '0;
	result.valid      = ex_mem.valid;
	result.rd         = ex_mem.rd;
	result.reg_write  = ex_mem.ctrl.reg_write;
	result.write_data = ex_mem.ctrl.mem_read ? dmem_rsp.dat_r : ex_mem.alu_result;
end

endmodule

`default_nettype wire

// File: hdl/data_path.sv
`timescale 1ns/1ps
`default_nettype none

module data_path import core_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	// instruction rom, combinational read
	output word_t   instr_addr,
	input  word_t   instr,
	// data memory, wishbone classic
	output wb_req_t dmem_req,
	input  wb_rsp_t dmem_rsp
);

word_t     pc;
word_t     fd_instr;
word_t     fd_pc;
logic      fd_valid;
logic      hold;                  // pc + fetch reg freeze
logic      flush;                 // taken branch that moves on
logic      load_use;
logic      mem_busy;
logic      redirect;
word_t     redirect_pc;
reg_addr_t rs1;
reg_addr_t rs2;
word_t     rs1_data;
word_t     rs2_data;
id_ex_t    decoded;
id_ex_t    id_ex_d;
id_ex_t    id_ex_q;
ex_mem_t   ex_result;
ex_mem_t   ex_mem_q;
mem_wb_t   mem_result;
mem_wb_t   mem_wb_q;

assign instr_addr = pc;
assign hold       = mem_busy | load_use;
assign flush      = redirect & ~mem_busy;   // branch held while frozen

// fetch --------------------
fetch_unit u_fetch_unit (
	.clk(clk),
	.rst_n(rst_n),
	.hold(hold),
	.redirect(flush),
	.redirect_pc(redirect_pc),
	.instr(instr),
	.pc(pc),
	.fd_instr(fd_instr),
	.fd_pc(fd_pc),
	.fd_valid(fd_valid)
);

// decode --------------------
decoder u_decoder (
	.instr(fd_instr),
	.pc(fd_pc),
	.rs1_data(rs1_data),
	.rs2_data(rs2_data),
	.rs1(rs1),
	.rs2(rs2),
	.decoded(decoded)
);

regfile u_regfile (
	.clk(clk),
	.rs1(rs1),
	.rs2(rs2),
	.rs1_data(rs1_data),
	.rs2_data(rs2_data),
	.we(mem_wb_q.valid & mem_wb_q.reg_write),  // write-back port
	.rd(mem_wb_q.rd),
	.wdata(mem_wb_q.write_data)
);

// lw in execute feeding the decoding instr
assign load_use = id_ex_q.valid & id_ex_q.ctrl.mem_read & (id_ex_q.rd != '0)
	& ((id_ex_q.rd == rs1) | (id_ex_q.rd == rs2));

always_comb begin
	id_ex_d       = decoded;
	id_ex_d.valid = fd_valid & ~flush & ~load_use;   // bubble on stall or flush
end

// execute / memory --------------------
execute_stage u_execute_stage (
	.id_ex(id_ex_q),
	.ex_mem(ex_mem_q),
	.mem_wb(mem_wb_q),
	.result(ex_result),
	.redirect(redirect),
	.redirect_pc(redirect_pc)
);

mem_stage u_mem_stage (
	.clk(clk),
	.rst_n(rst_n),
	.ex_mem(ex_mem_q),
	.dmem_req(dmem_req),
	.dmem_rsp(dmem_rsp),
	.result(mem_result),
	.mem_busy(mem_busy)
);

// stage regs, all frozen while bus open
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		id_ex_q  <= '0;
		ex_mem_q <= '0;
		mem_wb_q <= '0;
	end else if (!mem_busy) begin
		id_ex_q  <= id_ex_d;
		ex_mem_q <= ex_result;
		mem_wb_q <= mem_result;     // lw data taken in ack cycle
	end
end

endmodule

`default_nettype wire

// File: tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------
// compare tasks
// --------------------
task automatic check_word(input string name, input word_t expected, input word_t actual);
	if (actual !== expected) begin
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		val_errs++;
	end
endtask

task automatic check_wb_req(input string name, input wb_req_t expected,
		input wb_req_t actual);
	if (actual !== expected) begin
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		val_errs++;
	end
endtask

// 32-bit xorshift, shifts 13 / 17 / 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// --------------------
// rv32i encoders
// --------------------
function automatic word_t r_type_word(input logic [6:0] f7, input logic [2:0] f3,
		input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t addi_word(input reg_addr_t rd, input reg_addr_t rs1,
		input logic [11:0] imm);
	return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic word_t lw_word(input reg_addr_t rd, input reg_addr_t rs1,
		input logic [11:0] imm);
	return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic word_t sw_word(input reg_addr_t rs2, input reg_addr_t rs1,
		input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// ne=0 beq, ne=1 bne; off is the byte offset, bit 0 dropped
function automatic word_t branch_word(input logic ne, input reg_addr_t rs1,
		input reg_addr_t rs2, input logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
endfunction

`endif

// File: tests/tb_data_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module tb_data_path import core_pkg::*; ();

localparam word_t SENTINEL_ADR = 32'h0000_07fc;   // last store of every program

logic    clk;
logic    rst_n;
word_t   instr_addr;
word_t   instr;
wb_req_t dmem_req;
wb_rsp_t dmem_rsp;

word_t   rom [0:255];                   // instruction rom, word indexed
word_t   mem [0:1023];                  // 4 KB data memory
int      prog_len;
int      val_errs = 0;
int      other_errs = 0;

// memory model state
logic        rand_ack = 1'b0;           // 0: ack in the first cycle
logic [31:0] rng = 32'h053d_f249;
logic        bus_open = 1'b0;
logic        ack_sent = 1'b0;
logic        sentinel_seen = 1'b0;
wb_req_t     first_req = '0;            // request as seen in its first cycle
int          delay_left = 0;
logic [9:0]  mem_idx;
word_t       wr_adr [$];                // data writes in bus order
word_t       wr_dat [$];
word_t       exp_adr [$];
word_t       exp_dat [$];

`include "tb_checks.svh"

data_path u_data_path (
	.clk(clk),
	.rst_n(rst_n),
	.instr_addr(instr_addr),
	.instr(instr),
	.dmem_req(dmem_req),
	.dmem_rsp(dmem_rsp)
);

assign instr = rom[instr_addr[9:2]];    // same-cycle read

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

// --------------------
// wishbone slave model
// --------------------
always @(posedge clk) begin
	#1;
	if (!rst_n) begin
		bus_open = 1'b0;
		ack_sent = 1'b0;
		dmem_rsp = '0;
	end else if (ack_sent) begin
		ack_sent = 1'b0;                // ack is one cycle wide
		dmem_rsp = '0;
		if (dmem_req.cyc || dmem_req.stb) begin
			$display("at %0t cyc or stb stayed high in the cycle after ack", $time);
			other_errs++;
		end
	end else if (dmem_req.stb) begin
		if (!bus_open) begin
			bus_open   = 1'b1;
			first_req  = dmem_req;
			delay_left = 0;
			if (rand_ack) begin
				rng        = xorshift32(rng);
				delay_left = int'(rng[1:0]);   // 0..3 wait cycles
			end
		end else begin
			check_wb_req("dmem_req", first_req, dmem_req);   // must hold until ack
		end
		if (delay_left == 0) begin
			mem_idx          = dmem_req.adr[11:2];
			dmem_rsp.ack     = 1'b1;
			dmem_rsp.dat_r   = mem[mem_idx];
			if (dmem_req.we) begin
				mem[mem_idx] = dmem_req.dat_w;
				if (dmem_req.adr == SENTINEL_ADR) begin
					sentinel_seen = 1'b1;
				end else begin
					wr_adr.push_back(dmem_req.adr);
					wr_dat.push_back(dmem_req.dat_w);
				end
			end
			bus_open = 1'b0;
			ack_sent = 1'b1;
		end else begin
			delay_left--;
		end
	end
end

// whole-address fill pattern
function automatic word_t fill_word(input word_t adr);
	return adr ^ 32'h5a5a_0000 ^ {adr[15:0], adr[31:16]};
endfunction

// --------------------
// program and run helpers
// --------------------
task automatic init_memory();
	for (int i = 0; i < 1024; i++) mem[i] = fill_word(word_t'(i) << 2);
endtask

task automatic clear_program();
	for (int i = 0; i < 256; i++) rom[i] = `NOP_INSTR;
	prog_len = 0;
	exp_adr.delete();
	exp_dat.delete();
endtask

task automatic emit(input word_t w);
	rom[prog_len] = w;
	prog_len++;
endtask

task automatic expect_store(input word_t adr, input word_t dat);
	exp_adr.push_back(adr);
	exp_dat.push_back(dat);
endtask

// sentinel store, then beq x0,x0,0 spins
task automatic finish_program();
	emit(sw_word(5'd0, 5'd0, SENTINEL_ADR[11:0]));
	emit(branch_word(1'b0, 5'd0, 5'd0, 13'd0));
endtask

task automatic check_idle(input string when_s);
	check_word({"dmem_req.cyc ", when_s}, '0, word_t'(dmem_req.cyc));
	check_word({"dmem_req.stb ", when_s}, '0, word_t'(dmem_req.stb));
	check_word({"instr_addr ", when_s}, `RESET_PC, instr_addr);
endtask

task automatic reset_dut();
	@(posedge clk);
	#1;
	rst_n = 1'b0;
	repeat (3) begin
		@(posedge clk);
		#1;
		check_idle("in reset");
	end
	rst_n = 1'b1;
	#1;
	check_idle("after reset");          // before the first fetch edge
endtask

task automatic wait_for_sentinel(input int limit);
	int n;
	n = 0;
	while (!sentinel_seen && n < limit) begin
		@(posedge clk);
		n++;
	end
	if (!sentinel_seen) begin
		$display("timeout: no sentinel store within %0d cycles", limit);
		other_errs++;
	end
endtask

task automatic run_program();
	init_memory();
	wr_adr.delete();
	wr_dat.delete();
	sentinel_seen = 1'b0;
	reset_dut();
	wait_for_sentinel(2000);
endtask

task automatic compare_log(input string test);
	if (wr_adr.size() != exp_adr.size()) begin
		$display("%s: saw %0d data writes, expected %0d", test, wr_adr.size(), exp_adr.size());
		other_errs++;
	end else begin
		foreach (exp_adr[i]) begin
			check_word($sformatf("%s write %0d adr", test, i), exp_adr[i], wr_adr[i]);
			check_word($sformatf("%s write %0d dat", test, i), exp_dat[i], wr_dat[i]);
		end
	end
endtask

// --------------------
// programs
// --------------------
// back-to-back dependences and two load-use pairs
task automatic build_hazard_program();
	word_t r1;
	word_t r2;
	word_t r3;
	word_t r4;
	word_t r6;
	word_t r8;
	r1 = 32'd5;
	r2 = r1 + 32'd3;
	r3 = r2 + r1;
	r4 = r3 - r2;
	r6 = r3 + r1;                       // x5 loads r3 back
	r8 = fill_word(32'h200) + 32'd1;
	clear_program();
	emit(addi_word(5'd1, 5'd0, 12'd5));
	emit(addi_word(5'd2, 5'd1, 12'd3));
	emit(r_type_word(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));   // add
	emit(r_type_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));   // sub
	emit(sw_word(5'd4, 5'd0, 12'h100));
	emit(sw_word(5'd3, 5'd0, 12'h104));
	emit(lw_word(5'd5, 5'd0, 12'h104));
	emit(r_type_word(7'h00, 3'b000, 5'd6, 5'd5, 5'd1));   // uses lw right away
	emit(sw_word(5'd6, 5'd0, 12'h108));
	emit(lw_word(5'd7, 5'd0, 12'h200));                   // untouched fill word
	emit(addi_word(5'd8, 5'd7, 12'd1));
	emit(sw_word(5'd8, 5'd0, 12'h10c));
	emit(lw_word(5'd9, 5'd0, 12'h100));
	emit(sw_word(5'd9, 5'd0, 12'h110));                   // load feeds store data
	expect_store(32'h100, r4);
	expect_store(32'h104, r3);
	expect_store(32'h108, r6);
	expect_store(32'h10c, r8);
	expect_store(32'h110, r4);
	finish_program();
endtask

task automatic build_branch_program();
	clear_program();
	emit(addi_word(5'd1, 5'd0, 12'd7));
	emit(addi_word(5'd2, 5'd0, 12'd7));
	emit(sw_word(5'd1, 5'd0, 12'h100));
	emit(branch_word(1'b0, 5'd1, 5'd2, 13'd12));   // beq taken, skip 2
	emit(sw_word(5'd1, 5'd0, 12'h104));            // shadow
	emit(sw_word(5'd2, 5'd0, 12'h108));            // shadow
	emit(addi_word(5'd3, 5'd0, 12'd9));
	emit(branch_word(1'b1, 5'd1, 5'd2, 13'd8));    // bne, 7 == 7, falls through
	emit(sw_word(5'd3, 5'd0, 12'h10c));
	emit(branch_word(1'b1, 5'd1, 5'd3, 13'd8));    // bne taken
	emit(sw_word(5'd3, 5'd0, 12'h110));            // shadow
	emit(sw_word(5'd2, 5'd0, 12'h114));
	expect_store(32'h100, 32'd7);
	expect_store(32'h10c, 32'd9);
	expect_store(32'h114, 32'd7);
	finish_program();
endtask

// --------------------
// tests
// --------------------
task automatic test_reset();
	clear_program();
	finish_program();                   // idle checks run inside reset_dut
	run_program();
	compare_log("reset");
endtask

task automatic test_alu_ops();
	word_t a;
	word_t b;
	word_t res [8];
	int    i;
	a      = 32'd1443;                  // 12'h5a3
	b      = 32'hffff_fed4;             // -300
	res[0] = a + b;
	res[1] = a - b;
	res[2] = a & b;
	res[3] = a | b;
	res[4] = a ^ b;
	res[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
	res[6] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
	res[7] = a + 32'hffff_fff9;         // addi -7
	clear_program();
	emit(addi_word(5'd1, 5'd0, 12'h5a3));
	emit(addi_word(5'd2, 5'd0, 12'hed4));
	emit(r_type_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));   // add
	emit(r_type_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));   // sub
	emit(r_type_word(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));   // and
	emit(r_type_word(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));   // or
	emit(r_type_word(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));   // xor
	emit(r_type_word(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));   // slt a<b
	emit(r_type_word(7'h00, 3'b010, 5'd9, 5'd2, 5'd1));   // slt b<a
	emit(addi_word(5'd10, 5'd1, 12'hff9));
	for (i = 0; i < 8; i++) begin
		emit(sw_word(reg_addr_t'(3 + i), 5'd0, 12'(32'h100 + 4 * i)));
		expect_store(32'h100 + 4 * i, res[i]);
	end
	finish_program();
	run_program();
	compare_log("alu");
endtask

task automatic test_hazards();
	build_hazard_program();
	run_program();
	compare_log("hazard");
endtask

task automatic test_branches();
	build_branch_program();
	run_program();
	compare_log("branch");
endtask

// same programs, same stores as with zero-delay ack
task automatic test_random_ack();
	rand_ack = 1'b1;
	build_hazard_program();
	run_program();
	compare_log("random ack hazard");
	build_branch_program();
	run_program();
	compare_log("random ack branch");
	rand_ack = 1'b0;
endtask

initial begin
	rst_n    = 1'b0;
	dmem_rsp = '0;
	clear_program();
	init_memory();
	test_reset();
	test_alu_ops();
	test_hazards();
	test_branches();
	test_random_ack();
	$display("errors: %0d value, %0d protocol or timeout", val_errs, other_errs);
	if (val_errs == 0 && other_errs == 0) begin
		$display("Done: no errors");
	end else begin
		$display("Done: errors found");
	end
	$finish;
end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
+incdir+tests
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/data_path.sv
tests/tb_data_path.sv

// File: Makefile
run: obj_dir/Vtb_data_path
	obj_dir/Vtb_data_path | tee sim.log
	grep -q "^Done: no errors$$" sim.log

obj_dir/Vtb_data_path: vlog.f $(wildcard hdl/*.sv hdl/*.svh tests/*.sv tests/*.svh)
	verilator --binary --timing -Wno-fatal --top-module tb_data_path -f vlog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
